/* fetch_top.f */
verilog/fetch_pkg.sv
verilog/ibus_if.sv
verilog/insn_tcm.sv
verilog/fetch_tcm.sv
verilog/fetch_ctrl.sv
verilog/fetch_top.sv
testbench/fetch_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := fetch_tb
RTL_TOP    := fetch_top
FILELIST   := fetch_top.f
OBJ_DIR    := obj_dir
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* testbench/fetch_tb.sv */
/* Testbench for the fetch front end that loads programs over AXI4-Lite and
   checks the instruction stream against a walk of the program */
`timescale 1ns/1ps

module fetch_tb import fetch_pkg::*; ();

   // Instructions expected over all tests
   // The watchdog budget scales with this count
   localparam int EXPECTED_INSNS  = 32 + 32 + 7 + 7 + 5 + 6;
   localparam int WATCHDOG_CYCLES = 200 * EXPECTED_INSNS;

   logic              clk = 1'b0;
   logic              rst;
   logic              run_i;
   logic              flag_i;
   logic [XLEN-1:0]   s_awaddr_i;
   logic              s_awvalid_i;
   logic              s_awready_o;
   logic [XLEN-1:0]   s_wdata_i;
   logic [STRB_W-1:0] s_wstrb_i;
   logic              s_wvalid_i;
   logic              s_wready_o;
   logic [1:0]        s_bresp_o;
   logic              s_bvalid_o;
   logic              s_bready_i;
   logic [INSN_W-1:0] insn_o;
   logic [XLEN-1:0]   pc_o;
   logic              valid_o;
   logic              ready_i;
   logic              sleep_o;

   logic [31:0]       lfsr_q = 32'h412;
   logic [31:0]       prog_q [$];
   logic [31:0]       ref_mem [TCM_WORDS];
   logic [31:0]       exp_pc_q [$];
   logic [31:0]       exp_insn_q [$];

   fetch_top u_fetch_top (
      .clk         (clk),
      .rst         (rst),
      .run_i       (run_i),
      .flag_i      (flag_i),
      .s_awaddr_i  (s_awaddr_i),
      .s_awvalid_i (s_awvalid_i),
      .s_awready_o (s_awready_o),
      .s_wdata_i   (s_wdata_i),
      .s_wstrb_i   (s_wstrb_i),
      .s_wvalid_i  (s_wvalid_i),
      .s_wready_o  (s_wready_o),
      .s_bresp_o   (s_bresp_o),
      .s_bvalid_o  (s_bvalid_o),
      .s_bready_i  (s_bready_i),
      .insn_o      (insn_o),
      .pc_o        (pc_o),
      .valid_o     (valid_o),
      .ready_i     (ready_i),
      .sleep_o     (sleep_o)
   );

   always #10 clk = ~clk;

   initial
   begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Test FAILED");
      $fatal(1, "Watchdog expired after %0d cycles before the tests finished",
             WATCHDOG_CYCLES);
   end

   task automatic check(input string name, input logic [31:0] expected,
                        input logic [31:0] actual);
      if (actual !== expected)
      begin
         $display("FAILED %s: expected %h, actual %h", name, expected, actual);
         $display("Test FAILED");
         $fatal(1, "Value mismatch in %s", name);
      end
   endtask

   // Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   task automatic draw_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         v      = {v[30:0], lfsr_q[0]};
         lfsr_q = lfsr_next(lfsr_q);
      end
   endtask

   // PC relative jump or branch word with the immediate in words
   function automatic logic [31:0] jump_word(input logic [5:0] opc,
                                             input logic [31:0] from_pc,
                                             input logic [31:0] to_pc);
      logic [31:0] delta;
      delta = to_pc - from_pc;
      return {opc, delta[27:2]};
   endfunction

   task automatic add_nop();
      logic [31:0] r;
      draw_bits(16, r);
      prog_q.push_back({8'h15, 8'h00, r[15:0]});
   endtask

   task automatic reset_dut();
      @(posedge clk);
      #1;
      rst     = 1'b1;
      run_i   = 1'b0;
      ready_i = 1'b1;
      repeat (10) @(posedge clk);
      #1;
      rst = 1'b0;
   endtask

   task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
                            output logic [1:0] resp);
      @(posedge clk);
      #1;
      s_awaddr_i  = addr;
      s_awvalid_i = 1'b1;
      s_wdata_i   = data;
      s_wstrb_i   = '1;
      s_wvalid_i  = 1'b1;
      @(negedge clk);
      while (!(s_awready_o && s_wready_o))
         @(negedge clk);
      @(posedge clk);
      #1;
      s_awvalid_i = 1'b0;
      s_wvalid_i  = 1'b0;
      s_bready_i  = 1'b1;
      @(negedge clk);
      while (!s_bvalid_o)
         @(negedge clk);
      resp = s_bresp_o;
      @(posedge clk);
      #1;
      s_bready_i = 1'b0;
   endtask

   // Writes prog_q from base and mirrors it into the model memory
   task automatic load_program(input logic [31:0] base);
      logic [31:0] addr;
      logic [1:0]  resp;
      foreach (prog_q[i])
      begin
         addr = base + 32'(4 * i);
         axi_write(addr, prog_q[i], resp);
         check("load bresp", 32'(RESP_OKAY), 32'(resp));
         ref_mem[addr[11:2]] = prog_q[i];
      end
      prog_q.delete();
   endtask

   // Walks the loaded program from the reset PC up to the jump-to-self
   task automatic walk_program(input logic flag, input int n);
      logic [31:0] pc;
      logic [31:0] insn;
      logic [5:0]  opc;
      logic        taken;
      exp_pc_q.delete();
      exp_insn_q.delete();
      pc = RESET_PC;
      while (exp_pc_q.size() < n)
      begin
         if (pc[31:12] != '0)
            pc = EXC_VECTOR;
         else
         begin
            insn = ref_mem[pc[11:2]];
            exp_pc_q.push_back(pc);
            exp_insn_q.push_back(insn);
            if (insn == '0)
               break;
            opc   = insn[31:26];
            taken = (opc == 6'h00) || (opc == 6'h01) ||
                    (opc == 6'h04 && flag) || (opc == 6'h03 && !flag);
            if (taken)
               pc = pc + {{4{insn[25]}}, insn[25:0], 2'b00};
            else
               pc = pc + 32'd4;
         end
      end
   endtask

   task automatic expect_stream(input string name, input logic bp, input int n);
      logic [31:0] r;
      int          got;
      walk_program(flag_i, n);
      check({name, " model length"}, 32'(n), 32'(exp_pc_q.size()));
      got = 0;
      while (got < n)
      begin
         @(posedge clk);
         #1;
         if (bp)
         begin
            draw_bits(1, r);
            ready_i = r[0];
         end
         else
            ready_i = 1'b1;
         @(negedge clk);
         if (valid_o && ready_i)
         begin
            check({name, " pc"}, exp_pc_q[got], pc_o);
            check({name, " insn"}, exp_insn_q[got], insn_o);
            got++;
         end
      end
   endtask

   task automatic start_run(input logic flag);
      @(posedge clk);
      #1;
      flag_i = flag;
      run_i  = 1'b1;
   endtask

   task automatic straight_line_fetch();
      $display("straight-line fetch");
      reset_dut();
      for (int i = 0; i < 32; i++)
         add_nop();
      load_program(RESET_PC);
      start_run(1'b0);
      expect_stream("straight", 1'b0, 32);
   endtask

   // Reuses the straight-line program still held in the TCM
   task automatic backpressure_stream();
      $display("back-pressure");
      reset_dut();
      start_run(1'b0);
      expect_stream("backpressure", 1'b1, 32);
   endtask

   task automatic branch_paths();
      $display("jumps and branches");
      reset_dut();
      add_nop();
      prog_q.push_back(jump_word(OPC_J, 32'h104, 32'h110));
      add_nop();
      add_nop();
      prog_q.push_back(jump_word(OPC_BF, 32'h110, 32'h11C));
      add_nop();
      prog_q.push_back(jump_word(OPC_BNF, 32'h118, 32'h124));
      add_nop();
      // l.jr r9 goes through as a plain word
      prog_q.push_back({6'(OPC_JR), 26'h000_4800});
      prog_q.push_back(jump_word(OPC_JAL, 32'h124, 32'h12C));
      add_nop();
      prog_q.push_back(32'h0);
      load_program(RESET_PC);
      start_run(1'b0);
      expect_stream("branch flag0", 1'b0, 7);
      reset_dut();
      start_run(1'b1);
      expect_stream("branch flag1", 1'b0, 7);
   endtask

   task automatic sleep_on_self_jump();
      $display("sleep on jump-to-self");
      reset_dut();
      for (int i = 0; i < 4; i++)
         add_nop();
      prog_q.push_back(32'h0);
      add_nop();
      load_program(RESET_PC);
      start_run(1'b0);
      expect_stream("sleep", 1'b0, 5);
      while (!sleep_o)
         @(negedge clk);
      repeat (50)
      begin
         @(negedge clk);
         check("sleep valid_o", 32'd0, 32'(valid_o));
         check("sleep sleep_o", 32'd1, 32'(sleep_o));
      end
   endtask

   task automatic bus_error_redirect();
      logic [1:0] resp;
      $display("bus error and exception");
      reset_dut();
      add_nop();
      add_nop();
      prog_q.push_back(jump_word(OPC_J, 32'h108, 32'h2000));
      add_nop();
      load_program(RESET_PC);
      // Exception handler
      add_nop();
      add_nop();
      prog_q.push_back(32'h0);
      load_program(EXC_VECTOR);
      axi_write(32'h2000, 32'hDEAD_BEEF, resp);
      check("out of range bresp", 32'(RESP_SLVERR), 32'(resp));
      start_run(1'b0);
      expect_stream("bus error", 1'b0, 6);
   endtask

   initial
   begin
      rst         = 1'b1;
      run_i       = 1'b0;
      flag_i      = 1'b0;
      s_awaddr_i  = '0;
      s_awvalid_i = 1'b0;
      s_wdata_i   = '0;
      s_wstrb_i   = '0;
      s_wvalid_i  = 1'b0;
      s_bready_i  = 1'b0;
      ready_i     = 1'b1;
      for (int i = 0; i < TCM_WORDS; i++)
         ref_mem[i] = '0;

      straight_line_fetch();
      backpressure_stream();
      branch_paths();
      sleep_on_self_jump();
      bus_error_redirect();

      $display("Test OK");
      $finish;
   end

endmodule

/* verilog/fetch_top.sv */
/* Fetch front end top, joins the TCM, the fetch unit and the advance
   controller */
`timescale 1ns/1ps

module fetch_top import fetch_pkg::*;
(
   input  logic              clk,
   input  logic              rst,
   input  logic              run_i,
   input  logic              flag_i,
   input  logic [XLEN-1:0]   s_awaddr_i,
   input  logic              s_awvalid_i,
   output logic              s_awready_o,
   input  logic [XLEN-1:0]   s_wdata_i,
   input  logic [STRB_W-1:0] s_wstrb_i,
   input  logic              s_wvalid_i,
   output logic              s_wready_o,
   output logic [1:0]        s_bresp_o,
   output logic              s_bvalid_o,
   input  logic              s_bready_i,
   output logic [INSN_W-1:0] insn_o,
   output logic [XLEN-1:0]   pc_o,
   output logic              valid_o,
   input  logic              ready_i,
   output logic              sleep_o
);

   logic [INSN_W-1:0] decode_insn;
   logic [XLEN-1:0]   decode_pc;
   logic              decode_valid;
   logic              decode_ibus_err;
   logic              padv;
   logic              branch_occur;
   logic [XLEN-1:0]   branch_dest;
   logic              take_exception;

   ibus_if u_ibus ();

   insn_tcm u_insn_tcm (
      .clk         (clk),
      .rst         (rst),
      .ibus        (u_ibus.tcm),
      .s_awaddr_i  (s_awaddr_i),
      .s_awvalid_i (s_awvalid_i),
      .s_awready_o (s_awready_o),
      .s_wdata_i   (s_wdata_i),
      .s_wstrb_i   (s_wstrb_i),
      .s_wvalid_i  (s_wvalid_i),
      .s_wready_o  (s_wready_o),
      .s_bresp_o   (s_bresp_o),
      .s_bvalid_o  (s_bvalid_o),
      .s_bready_i  (s_bready_i)
   );

   fetch_tcm u_fetch_tcm (
      .clk               (clk),
      .rst               (rst),
      .run_i             (run_i),
      .ibus              (u_ibus.fetch),
      .padv_i            (padv),
      .branch_occur_i    (branch_occur),
      .branch_dest_i     (branch_dest),
      .take_exception_i  (take_exception),
      .flag_i            (flag_i),
      .decode_insn_o     (decode_insn),
      .decode_pc_o       (decode_pc),
      .decode_valid_o    (decode_valid),
      .decode_ibus_err_o (decode_ibus_err),
      .sleep_o           (sleep_o)
   );

   fetch_ctrl u_fetch_ctrl (
      .clk               (clk),
      .rst               (rst),
      .decode_insn_i     (decode_insn),
      .decode_pc_i       (decode_pc),
      .decode_valid_i    (decode_valid),
      .decode_ibus_err_i (decode_ibus_err),
      .flag_i            (flag_i),
      .padv_o            (padv),
      .branch_occur_o    (branch_occur),
      .branch_dest_o     (branch_dest),
      .take_exception_o  (take_exception),
      .insn_o            (insn_o),
      .pc_o              (pc_o),
      .valid_o           (valid_o),
      .ready_i           (ready_i)
   );

endmodule

/* verilog/fetch_ctrl.sv */
/* Pipeline advance and branch resolve, feeds the outward instruction
   stream and turns fetch bus errors into an exception redirect */
`timescale 1ns/1ps

module fetch_ctrl import fetch_pkg::*;
(
   input  logic              clk,
   input  logic              rst,
   input  logic [INSN_W-1:0] decode_insn_i,
   input  logic [XLEN-1:0]   decode_pc_i,
   input  logic              decode_valid_i,
   input  logic              decode_ibus_err_i,
   input  logic              flag_i,
   output logic              padv_o,
   output logic              branch_occur_o,
   output logic [XLEN-1:0]   branch_dest_o,
   output logic              take_exception_o,
   output logic [INSN_W-1:0] insn_o,
   output logic [XLEN-1:0]   pc_o,
   output logic              valid_o,
   input  logic              ready_i
);

   logic [IMM_W-1:0] imm;
   logic             slot_free;

   // Output slot can take a word when empty or being drained this cycle
   assign slot_free = ~valid_o | ready_i;

   // Words marked with a bus error never enter the stream
   assign padv_o           = decode_valid_i & ~decode_ibus_err_i & slot_free;
   assign take_exception_o = decode_valid_i & decode_ibus_err_i;

   // PC relative target, immediate counts words
   assign imm           = decode_insn_i[IMM_W-1:0];
   assign branch_dest_o = decode_pc_i + {{(XLEN-IMM_W-2){imm[IMM_W-1]}}, imm, 2'b00};
   assign branch_occur_o = padv_o & insn_branches(decode_insn_i, flag_i);

   always_ff @(posedge clk)
   begin
      if (rst)
         valid_o <= 1'b0;
      else if (padv_o)
         valid_o <= 1'b1;
      else if (ready_i)
         valid_o <= 1'b0;
   end

   always_ff @(posedge clk)
   begin
      if (padv_o)
      begin
         insn_o <= decode_insn_i;
         pc_o   <= decode_pc_i;
      end
   end

   // The branch itself still goes out, in the slot right after it resolves
   assert property (@(posedge clk) disable iff (rst)
      branch_occur_o |-> padv_o ##1 (valid_o && pc_o == $past(decode_pc_i)));

endmodule

/* verilog/fetch_tcm.sv */
/* Fetch unit for the TCM: bus PC with pipelined requests, one-entry buffer
   under stall, early branch detect and sleep on jump-to-self */
`timescale 1ns/1ps

module fetch_tcm import fetch_pkg::*;
(
   input  logic              clk,
   input  logic              rst,
   input  logic              run_i,
   ibus_if.fetch             ibus,
   input  logic              padv_i,
   input  logic              branch_occur_i,
   input  logic [XLEN-1:0]   branch_dest_i,
   input  logic              take_exception_i,
   input  logic              flag_i,
   output logic [INSN_W-1:0] decode_insn_o,
   output logic [XLEN-1:0]   decode_pc_o,
   output logic              decode_valid_o,
   output logic              decode_ibus_err_o,
   output logic              sleep_o
);

   fetch_state_e      state_q;
   logic [XLEN-1:0]   pc_q;
   logic [XLEN-1:0]   resp_pc_q;
   logic              resp_pend_q;
   logic              resp_ok;
   logic              resp_err;
   logic              resp_any;
   logic              will_branch;
   logic              buf_valid_q;
   logic              buf_err_q;
   logic [INSN_W-1:0] buf_insn_q;
   logic [XLEN-1:0]   buf_pc_q;
   logic              buf_next;
   logic              go_sleep;
   logic              redirect;

   // Responses count only for requests issued on the current path
   assign resp_ok  = resp_pend_q & ibus.ack;
   assign resp_err = resp_pend_q & ibus.err;
   assign resp_any = resp_ok | resp_err;

   // Early look at the incoming word, nothing past a taken branch is fetched
   assign will_branch = resp_ok & insn_branches(ibus.dat, flag_i);

   // Buffer ends up full when decode stalls and a second word is around
   assign buf_next = decode_valid_o & ~padv_i & (buf_valid_q | resp_any);

   assign go_sleep = decode_valid_o & padv_i & (decode_insn_o == '0);
   assign redirect = branch_occur_i & padv_i;

   assign ibus.adr = pc_q;
   assign ibus.req = (state_q == FS_RUN) & ~buf_next & ~resp_err & ~will_branch;
   assign sleep_o  = (state_q == FS_SLEEP);

   always_ff @(posedge clk)
   begin
      if (rst)
         state_q <= FS_IDLE;
      else if (take_exception_i)
         state_q <= FS_RUN;
      else if (go_sleep)
         state_q <= FS_SLEEP;
      else if (redirect)
         state_q <= FS_RUN;
      else
      begin
         case (state_q)
            FS_IDLE:
               if (run_i)
                  state_q <= FS_RUN;
            FS_RUN:
               // Hold off until the controller resolves the branch or error
               if (resp_err | will_branch)
                  state_q <= FS_REDIRECT;
            default:
               state_q <= state_q;
         endcase
      end
   end

   // Bus PC moves on with every request issued
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         pc_q        <= RESET_PC;
         resp_pend_q <= 1'b0;
      end
      else if (take_exception_i)
      begin
         pc_q        <= EXC_VECTOR;
         resp_pend_q <= 1'b0;
      end
      else if (redirect)
      begin
         pc_q        <= branch_dest_i;
         resp_pend_q <= 1'b0;
      end
      else
      begin
         resp_pend_q <= ibus.req;
         if (ibus.req)
            pc_q <= pc_q + XLEN'(4);
      end
   end

   always_ff @(posedge clk)
   begin
      if (ibus.req)
         resp_pc_q <= pc_q;
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         decode_valid_o <= 1'b0;
         buf_valid_q    <= 1'b0;
      end
      else if (take_exception_i | go_sleep | redirect)
      begin
         decode_valid_o <= 1'b0;
         buf_valid_q    <= 1'b0;
      end
      else
      begin
         if (padv_i | ~decode_valid_o)
            decode_valid_o <= buf_valid_q | resp_any;
         buf_valid_q <= buf_next;
      end
   end

   // Decode slot takes the buffered word first, else the word on the bus
   always_ff @(posedge clk)
   begin
      if (take_exception_i | go_sleep | redirect)
         decode_insn_o <= NOP_INSN;
      else if (padv_i | ~decode_valid_o)
      begin
         if (buf_valid_q)
         begin
            decode_insn_o     <= buf_insn_q;
            decode_pc_o       <= buf_pc_q;
            decode_ibus_err_o <= buf_err_q;
         end
         else
         begin
            decode_insn_o     <= resp_ok ? ibus.dat : NOP_INSN;
            decode_pc_o       <= resp_pc_q;
            decode_ibus_err_o <= resp_err;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (decode_valid_o & ~padv_i & ~buf_valid_q & resp_any)
      begin
         buf_insn_q <= ibus.dat;
         buf_pc_q   <= resp_pc_q;
         buf_err_q  <= resp_err;
      end
   end

   // Idle or asleep, the bus stays quiet and no answer comes back next cycle
   assert property (@(posedge clk) disable iff (rst)
      (state_q == FS_IDLE || state_q == FS_SLEEP) |->
         !ibus.req ##1 (!ibus.ack && !ibus.err));

   // A valid decode word was held, came from the buffer, or just arrived
   assert property (@(posedge clk) disable iff (rst)
      decode_valid_o |-> $past(decode_valid_o & ~padv_i) || $past(buf_valid_q) ||
                         $past(ibus.ack | ibus.err));

endmodule

/* verilog/insn_tcm.sv */
/* Instruction TCM with single-cycle reads on the instruction bus and
   byte-strobed AXI4-Lite writes for program loading */
`timescale 1ns/1ps

module insn_tcm import fetch_pkg::*;
(
   input  logic              clk,
   input  logic              rst,
   ibus_if.tcm               ibus,
   input  logic [XLEN-1:0]   s_awaddr_i,
   input  logic              s_awvalid_i,
   output logic              s_awready_o,
   input  logic [XLEN-1:0]   s_wdata_i,
   input  logic [STRB_W-1:0] s_wstrb_i,
   input  logic              s_wvalid_i,
   output logic              s_wready_o,
   output logic [1:0]        s_bresp_o,
   output logic              s_bvalid_o,
   input  logic              s_bready_i
);

   logic [INSN_W-1:0] mem [TCM_WORDS];
   logic [TCM_AW-1:0] rd_idx;
   logic [TCM_AW-1:0] wr_idx;
   logic              rd_in_range;
   logic              wr_in_range;
   logic              wr_fire;

   // Word index from the byte address
   // Only addresses with zero upper bits hit the TCM
   assign rd_idx      = ibus.adr[TCM_AW+1:2];
   assign rd_in_range = (ibus.adr[XLEN-1:TCM_AW+2] == '0);
   assign wr_idx      = s_awaddr_i[TCM_AW+1:2];
   assign wr_in_range = (s_awaddr_i[XLEN-1:TCM_AW+2] == '0);

   // AW and W are taken together and only one write is open until B returns
   assign wr_fire     = s_awvalid_i & s_wvalid_i & ~s_bvalid_o;
   assign s_awready_o = wr_fire;
   assign s_wready_o  = wr_fire;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         ibus.ack <= 1'b0;
         ibus.err <= 1'b0;
      end
      else
      begin
         ibus.ack <= ibus.req & rd_in_range;
         ibus.err <= ibus.req & ~rd_in_range;
      end
   end

   always_ff @(posedge clk)
   begin
      if (ibus.req)
         ibus.dat <= mem[rd_idx];
   end

   always_ff @(posedge clk)
   begin
      if (wr_fire & wr_in_range)
      begin
         for (int b = 0; b < STRB_W; b++)
         begin
            if (s_wstrb_i[b])
               mem[wr_idx][8*b +: 8] <= s_wdata_i[8*b +: 8];
         end
      end
   end

   // Write response comes one cycle after the accepted beat and holds until bready
   always_ff @(posedge clk)
   begin
      if (rst)
         s_bvalid_o <= 1'b0;
      else if (wr_fire)
         s_bvalid_o <= 1'b1;
      else if (s_bready_i)
         s_bvalid_o <= 1'b0;
   end

   always_ff @(posedge clk)
   begin
      if (wr_fire)
         s_bresp_o <= wr_in_range ? RESP_OKAY : RESP_SLVERR;
   end

   // A request is answered by ack or by err, never by both
   assert property (@(posedge clk) disable iff (rst)
      !(ibus.ack && ibus.err));

endmodule

/* verilog/ibus_if.sv */
/* Instruction bus between fetch and TCM, a request with address answered
   one cycle later by ack with data, or by err */
`timescale 1ns/1ps

interface ibus_if import fetch_pkg::*; ();

   logic              req;
   logic [XLEN-1:0]   adr;
   logic              ack;
   logic [INSN_W-1:0] dat;
   logic              err;

   // Fetch side issues requests
   modport fetch (
      output req,
      output adr,
      input  ack,
      input  dat,
      input  err
   );

   // TCM side answers them
   modport tcm (
      input  req,
      input  adr,
      output ack,
      output dat,
      output err
   );

endinterface

/* verilog/fetch_pkg.sv */
/* Fetch front end definitions: widths, TCM map, OR1K opcode and fetch
   state encodings, instruction field positions and the branch decode */
package fetch_pkg;

   localparam int XLEN      = 32;
   localparam int INSN_W    = 32;
   localparam int STRB_W    = XLEN / 8;

   // TCM holds 1024 words, byte addresses 0x000 to 0xFFF
   localparam int TCM_WORDS = 1024;
   localparam int TCM_AW    = $clog2(TCM_WORDS);

   localparam logic [XLEN-1:0] RESET_PC   = 32'h0000_0100;
   localparam logic [XLEN-1:0] EXC_VECTOR = 32'h0000_0200;

   // Major opcode sits in bits 31..26, jump immediate in bits 25..0
   localparam int OPC_LSB = 26;
   localparam int OPC_W   = 6;
   localparam int IMM_W   = 26;

   // AXI4-Lite write response codes
   localparam logic [1:0] RESP_OKAY   = 2'b00;
   localparam logic [1:0] RESP_SLVERR = 2'b10;

   typedef enum logic [OPC_W-1:0] {
      OPC_J    = 6'h00,
      OPC_JAL  = 6'h01,
      OPC_BNF  = 6'h03,
      OPC_BF   = 6'h04,
      OPC_NOP  = 6'h05,
      OPC_JR   = 6'h11,
      OPC_JALR = 6'h12
   } opcode_e;

   typedef enum logic [1:0] {
      FS_IDLE,
      FS_RUN,
      FS_REDIRECT,
      FS_SLEEP
   } fetch_state_e;

   // l.nop with zero fields, top byte 0x15
   localparam logic [INSN_W-1:0] NOP_INSN = {OPC_NOP, 2'b01, 24'h00_0000};

   // True when the word changes the fetch path under the given flag
   function automatic logic insn_branches(input logic [INSN_W-1:0] insn,
                                          input logic              flag);
      opcode_e opc;
      opc = opcode_e'(insn[OPC_LSB +: OPC_W]);
      case (opc)
         OPC_J, OPC_JAL:
            return 1'b1;
         OPC_BF:
            return flag;
         OPC_BNF:
            return ~flag;
         // Register-indirect jumps pass through as plain instructions
         OPC_NOP, OPC_JR, OPC_JALR:
            return 1'b0;
         default:
            return 1'b0;
      endcase
   endfunction

endpackage
